//--- hw/exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Datapath word width in bits
`define EXEC_XLEN    32

// Architectural register file size
`define EXEC_NREGS   32

// Register index width, log2 of EXEC_NREGS
`define EXEC_REG_AW  5

// Shift distance taken from rs2 or the immediate
`define EXEC_SHAMT_W 5

`endif

//--- hw/isa_pkg.sv
`include "exec_macros.svh"

package isa_pkg;

    // --------------------------------------------------
    // Major opcodes handled by the execute block
    // --------------------------------------------------
    typedef enum logic [6:0] {
        OP     = 7'b0110011,    // Register-register
        OP_IMM = 7'b0010011     // Register-immediate
    } opcode_e;

    // funct3 codes, shared by both groups
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;    // SRL or SRA by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 codes
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;  // SUB, SRA, SRAI

    // --------------------------------------------------
    // Instruction formats, MSB first
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0]              funct7;
        logic [`EXEC_REG_AW-1:0] rs2;
        logic [`EXEC_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`EXEC_REG_AW-1:0] rd;
        opcode_e                 opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]             imm12;     // Sign bit at [11]
        logic [`EXEC_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`EXEC_REG_AW-1:0] rd;
        opcode_e                 opcode;
    } i_fmt_t;

    // One 32-bit word seen either way, opcode picks the view
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

//--- hw/exec_pkg.sv
`include "exec_macros.svh"

package exec_pkg;

    // --------------------------------------------------
    // ALU operation select
    // --------------------------------------------------
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,        // Signed less-than
        SLTU,       // Unsigned less-than
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA
    } alu_op_e;

    // --------------------------------------------------
    // Decoder output, one per instruction
    // --------------------------------------------------
    typedef struct packed {
        logic                    valid;
        alu_op_e                 op;
        logic [`EXEC_REG_AW-1:0] rs1;
        logic [`EXEC_REG_AW-1:0] rs2;      // Zero for immediate forms
        logic [`EXEC_REG_AW-1:0] rd;
        logic                    use_imm;  // Operand two from imm
        logic [`EXEC_XLEN-1:0]   imm;      // Already sign-extended
    } ctrl_t;

    // Result of one instruction, also the regfile write port
    typedef struct packed {
        logic                    valid;
        logic [`EXEC_REG_AW-1:0] rd;
        logic [`EXEC_XLEN-1:0]   data;
    } wb_t;

endpackage

//--- hw/exec_decoder.sv
`include "exec_macros.svh"
`timescale 1ns/1ps

module exec_decoder (
    input  logic            clock,
    input  logic            rst,
    input  logic            instr_valid,   // One instruction per strobe
    input  isa_pkg::instr_u instr,
    output exec_pkg::ctrl_t ctrl,          // Registered control word
    output logic            illegal        // Single-cycle pulse
);

    isa_pkg::r_fmt_t r_view;
    isa_pkg::i_fmt_t i_view;
    logic [6:0]      shift_f7;             // Upper imm bits of SLLI/SRLI/SRAI
    logic            bad;                  // Encoding outside the covered set
    exec_pkg::ctrl_t ctrl_d;

    assign r_view   = instr.r;
    assign i_view   = instr.i;
    assign shift_f7 = i_view.imm12[11:5];

    // --------------------------------------------------
    // Combinational decode
    // --------------------------------------------------
    always_comb begin
        ctrl_d     = '0;
        bad        = 1'b0;
        ctrl_d.rs1 = r_view.rs1;           // Same slot in both formats
        ctrl_d.rd  = r_view.rd;
        case (r_view.opcode)
            isa_pkg::OP: begin
                ctrl_d.rs2 = r_view.rs2;
                case (r_view.funct3)
                    isa_pkg::F3_ADD_SUB: begin
                        ctrl_d.op = (r_view.funct7 == isa_pkg::F7_ALT) ?
                                    exec_pkg::SUB : exec_pkg::ADD;
                    end
                    isa_pkg::F3_SR: begin
                        ctrl_d.op = (r_view.funct7 == isa_pkg::F7_ALT) ?
                                    exec_pkg::SRA : exec_pkg::SRL;
                    end
                    isa_pkg::F3_SLL:  ctrl_d.op = exec_pkg::SLL;
                    isa_pkg::F3_SLT:  ctrl_d.op = exec_pkg::SLT;
                    isa_pkg::F3_SLTU: ctrl_d.op = exec_pkg::SLTU;
                    isa_pkg::F3_XOR:  ctrl_d.op = exec_pkg::XOR;
                    isa_pkg::F3_OR:   ctrl_d.op = exec_pkg::OR;
                    isa_pkg::F3_AND:  ctrl_d.op = exec_pkg::AND;
                endcase
                // Alt funct7 only pairs with ADD/SUB and SRL/SRA
                if (r_view.funct7 == isa_pkg::F7_ALT)
                    bad = !(r_view.funct3 inside {isa_pkg::F3_ADD_SUB, isa_pkg::F3_SR});
                else if (r_view.funct7 != isa_pkg::F7_BASE)
                    bad = 1'b1;
            end
            isa_pkg::OP_IMM: begin
                ctrl_d.use_imm = 1'b1;
                ctrl_d.imm     = {{(`EXEC_XLEN-12){i_view.imm12[11]}}, i_view.imm12};
                case (i_view.funct3)
                    isa_pkg::F3_ADD_SUB: ctrl_d.op = exec_pkg::ADD;  // No SUBI
                    isa_pkg::F3_SLT:     ctrl_d.op = exec_pkg::SLT;
                    isa_pkg::F3_SLTU:    ctrl_d.op = exec_pkg::SLTU;
                    isa_pkg::F3_XOR:     ctrl_d.op = exec_pkg::XOR;
                    isa_pkg::F3_OR:      ctrl_d.op = exec_pkg::OR;
                    isa_pkg::F3_AND:     ctrl_d.op = exec_pkg::AND;
                    isa_pkg::F3_SLL: begin
                        ctrl_d.op = exec_pkg::SLL;
                        bad       = (shift_f7 != isa_pkg::F7_BASE);
                    end
                    isa_pkg::F3_SR: begin
                        ctrl_d.op = (shift_f7 == isa_pkg::F7_ALT) ?
                                    exec_pkg::SRA : exec_pkg::SRL;
                        bad       = !(shift_f7 inside {isa_pkg::F7_BASE, isa_pkg::F7_ALT});
                    end
                endcase
                // Shifts keep only shamt as operand two
                if (i_view.funct3 inside {isa_pkg::F3_SLL, isa_pkg::F3_SR})
                    ctrl_d.imm = {{(`EXEC_XLEN-`EXEC_SHAMT_W){1'b0}},
                                  i_view.imm12[`EXEC_SHAMT_W-1:0]};
            end
            default: bad = 1'b1;           // Opcode not in this block
        endcase
        ctrl_d.valid = instr_valid && !bad;
    end

    // --------------------------------------------------
    // Decode register
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        ctrl    <= ctrl_d;
        illegal <= instr_valid && bad;
        if (rst) begin
            ctrl.valid <= 1'b0;
            illegal    <= 1'b0;
        end
    end

    // Only OP and OP-IMM words reach the ALU, and never as illegal
    a_valid_or_illegal: assert property (@(posedge clock) disable iff (rst)
        ctrl.valid |-> !illegal &&
                       ($past(instr.r.opcode) inside {isa_pkg::OP, isa_pkg::OP_IMM}));

endmodule

//--- hw/exec_regfile.sv
`include "exec_macros.svh"
`timescale 1ns/1ps

module exec_regfile (
    input  logic                    clock,
    input  logic                    rst,
    input  logic [`EXEC_REG_AW-1:0] rs1,
    input  logic [`EXEC_REG_AW-1:0] rs2,
    output logic [`EXEC_XLEN-1:0]   rs1_data,
    output logic [`EXEC_XLEN-1:0]   rs2_data,
    input  exec_pkg::wb_t           wb          // Next-state writeback from ALU
);

    // Storage for x1..x31 only
    logic [`EXEC_XLEN-1:0] regs [1:`EXEC_NREGS-1];

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 1; i < `EXEC_NREGS; i++)
                regs[i] <= '0;
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;     // Visible to next cycle's reads
        end
    end

    // Combinational reads with x0 forced to zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // Next-cycle read of a written index returns its data, or zero for x0
    a_write_then_read: assert property (@(posedge clock) disable iff (rst)
        wb.valid |=> (rs1 != $past(wb.rd)) ||
                     (rs1_data == (($past(wb.rd) == '0) ? '0 : $past(wb.data))));

endmodule

//--- hw/exec_alu.sv
`include "exec_macros.svh"
`timescale 1ns/1ps

module exec_alu #(
    parameter int BW = `EXEC_XLEN
) (
    input  logic            clock,
    input  logic            rst,
    input  exec_pkg::ctrl_t ctrl,
    input  logic [BW-1:0]   rs1_data,
    input  logic [BW-1:0]   rs2_data,
    output exec_pkg::wb_t   wb,        // Registered result
    output exec_pkg::wb_t   wb_next    // Next-state word for the regfile write
);

    logic [BW-1:0]            d1;
    logic [BW-1:0]            d2;
    logic                     choose_sub;
    logic [BW-1:0]            addend;
    logic [BW-1:0]            sum;
    logic                     lt_signed;
    logic                     lt_unsigned;
    logic [`EXEC_SHAMT_W-1:0] shamt;
    logic                     shr_fill;
    logic [2*BW-1:0]          shr_wide;
    logic [BW-1:0]            res;

    // --------------------------------------------------
    // Operand select
    // --------------------------------------------------
    assign d1 = rs1_data;
    assign d2 = ctrl.use_imm ? BW'($signed(ctrl.imm)) : rs2_data;

    // Shared adder subtracts as d1 + ~d2 + 1
    assign choose_sub = (ctrl.op == exec_pkg::SUB) || (ctrl.op == exec_pkg::SLT);
    assign addend     = choose_sub ? ~d2 : d2;
    assign sum        = d1 + addend + {{(BW-1){1'b0}}, choose_sub};

    // Sign bits decide when they differ, else the sign of the difference
    assign lt_signed   = (d1[BW-1] != d2[BW-1]) ? d1[BW-1] : sum[BW-1];
    assign lt_unsigned = d1 < d2;

    // One right shifter with the upper half filled by sign for SRA
    assign shamt    = d2[`EXEC_SHAMT_W-1:0];
    assign shr_fill = (ctrl.op == exec_pkg::SRA) && d1[BW-1];
    assign shr_wide = {{BW{shr_fill}}, d1} >> shamt;

    // --------------------------------------------------
    // Result mux
    // --------------------------------------------------
    always_comb begin
        case (ctrl.op)
            exec_pkg::ADD,
            exec_pkg::SUB:  res = sum;
            exec_pkg::SLT:  res = {{(BW-1){1'b0}}, lt_signed};
            exec_pkg::SLTU: res = {{(BW-1){1'b0}}, lt_unsigned};
            exec_pkg::AND:  res = d1 & d2;
            exec_pkg::OR:   res = d1 | d2;
            exec_pkg::XOR:  res = d1 ^ d2;
            exec_pkg::SLL:  res = d1 << shamt;
            exec_pkg::SRL,
            exec_pkg::SRA:  res = shr_wide[BW-1:0];   // Low half holds result
            default:        res = '0;
        endcase
    end

    assign wb_next.valid = ctrl.valid;
    assign wb_next.rd    = ctrl.rd;       // x0 kept here and dropped by the regfile
    assign wb_next.data  = res;

    // Writeback register
    always_ff @(posedge clock) begin
        wb <= wb_next;
        if (rst)
            wb.valid <= 1'b0;
    end

    // Adder-based signed compare agrees with a direct compare
    a_slt_matches: assert property (@(posedge clock) disable iff (rst)
        (ctrl.valid && ctrl.op == exec_pkg::SLT) |->
            lt_signed == ($signed(d1) < $signed(d2)));

endmodule

//--- hw/exec_core.sv
`include "exec_macros.svh"
`timescale 1ns/1ps

module exec_core (
    input  logic            clock,
    input  logic            rst,
    input  logic            instr_valid,  // Strobe, no handshake
    input  isa_pkg::instr_u instr,
    output exec_pkg::wb_t   wb,           // Two cycles after the strobe
    output logic            illegal       // One cycle after the strobe
);

    // --------------------------------------------------
    // Internal wires
    // --------------------------------------------------
    exec_pkg::ctrl_t       ctrl;          // Decode stage output
    logic [`EXEC_XLEN-1:0] rs1_data;
    logic [`EXEC_XLEN-1:0] rs2_data;
    exec_pkg::wb_t         wb_next;       // Write lands as wb registers

    // Control
    exec_decoder u_exec_decoder (
        .clock       (clock),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl        (ctrl),
        .illegal     (illegal)
    );

    // Register file, read by the decoded indices
    exec_regfile u_exec_regfile (
        .clock    (clock),
        .rst      (rst),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb_next)
    );

    // --------------------------------------------------
    // Execute and writeback
    // --------------------------------------------------
    exec_alu #(
        .BW (`EXEC_XLEN)
    ) u_exec_alu (
        .clock    (clock),
        .rst      (rst),
        .ctrl     (ctrl),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb),
        .wb_next  (wb_next)
    );

endmodule

//--- verif/exec_core_tb.sv
`include "exec_macros.svh"
`timescale 1ns/1ps

module exec_core_tb;

    logic                  clock;
    logic                  rst;
    logic                  instr_valid;
    isa_pkg::instr_u       instr;
    exec_pkg::wb_t         wb;
    logic                  illegal;

    logic [`EXEC_XLEN-1:0] model_regs [0:`EXEC_NREGS-1];  // Reference register state
    logic [31:0]           lcg_state;
    // Expected values, now = on the inputs, d1/d2 = one and two edges later
    exec_pkg::wb_t         exp_wb_now;
    exec_pkg::wb_t         exp_wb_d1;
    exec_pkg::wb_t         exp_wb_d2;
    logic                  exp_ill_now;
    logic                  exp_ill_d1;
    int                    ph_now;
    int                    ph_d1;
    int                    ph_d2;

    exec_core u_exec_core (
        .clock       (clock),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb),
        .illegal     (illegal)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;     // 20 ns period
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic string phase_name(input int ph);
        case (ph)
            1:       return "reset_zero";
            2:       return "reg_reg";
            3:       return "reg_imm";
            4:       return "dependent";
            5:       return "x0_write";
            6:       return "illegal";
            default: return "idle";
        endcase
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        isa_pkg::instr_u u;
        u.r.funct7 = f7;
        u.r.rs2    = rs2;
        u.r.rs1    = rs1;
        u.r.funct3 = f3;
        u.r.rd     = rd;
        u.r.opcode = isa_pkg::OP;
        return u;
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        isa_pkg::instr_u u;
        u.i.imm12  = imm;
        u.i.rs1    = rs1;
        u.i.funct3 = f3;
        u.i.rd     = rd;
        u.i.opcode = isa_pkg::OP_IMM;
        return u;
    endfunction

    // RV32I semantics straight from the ISA, opcodes as spec literals
    function automatic logic [31:0] ref_exec(input logic [31:0] w, output logic legal);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        alt;
        logic [31:0] res;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        a   = model_regs[w[19:15]];
        alt = (f7 == 7'h20);
        if (opc == 7'b0110011) begin                // OP
            b     = model_regs[w[24:20]];
            legal = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
        end else if (opc == 7'b0010011) begin       // OP-IMM
            b     = {{20{w[31]}}, w[31:20]};
            legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                    (f3 == 3'd5) ? (f7 == 7'h00 || alt) : 1'b1;
            if (f3 == 3'd0)
                alt = 1'b0;                         // ADDI never subtracts
        end else begin
            b     = '0;
            legal = 1'b0;
        end
        sh = b[4:0];
        case (f3)
            3'd0:    res = alt ? a - b : a + b;
            3'd1:    res = a << sh;
            3'd2:    res = {31'd0, $signed(a) < $signed(b)};
            3'd3:    res = {31'd0, a < b};
            3'd4:    res = a ^ b;
            3'd5:    res = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // Drive one instruction and update the model in program order
    task automatic issue(input logic [31:0] w, input int ph);
        logic        legal;
        logic [31:0] res;
        res = ref_exec(w, legal);
        instr            <= w;
        instr_valid      <= 1'b1;
        exp_ill_now      <= !legal;
        exp_wb_now.valid <= legal;
        exp_wb_now.rd    <= w[11:7];
        exp_wb_now.data  <= res;
        ph_now           <= ph;
        if (legal && w[11:7] != 5'd0)
            model_regs[w[11:7]] = res;
        @(posedge clock);
    endtask

    task automatic idle();
        instr       <= rand32();                  // Junk payload, no strobe
        instr_valid <= 1'b0;
        exp_ill_now <= 1'b0;
        exp_wb_now  <= '0;
        @(posedge clock);
    endtask

    task automatic wait_drain(input int limit);
        int  n;
        logic busy;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            busy = wb.valid || illegal || exp_wb_d1.valid || exp_wb_d2.valid;
        end while (busy && n < limit);
        if (busy) begin
            $display("Timeout: pipeline still busy after %0d cycles", limit);
            $display("Verification failed");
            $fatal(1, "drain timeout");
        end
    endtask

    // --------------------------------------------------
    // Expected pipeline and checks
    // --------------------------------------------------
    always @(posedge clock) begin
        if (rst) begin
            exp_wb_d1  <= '0;
            exp_wb_d2  <= '0;
            exp_ill_d1 <= 1'b0;
        end else begin
            exp_wb_d1  <= exp_wb_now;
            exp_wb_d2  <= exp_wb_d1;    // wb shows two edges after the strobe
            exp_ill_d1 <= exp_ill_now;  // illegal one edge after
        end
        ph_d1 <= ph_now;
        ph_d2 <= ph_d1;
    end

    a_illegal: assert property (@(posedge clock) disable iff (rst) illegal == exp_ill_d1)
        else begin
            $display("ERROR %s: illegal expected %0b actual %0b",
                     phase_name($sampled(ph_d1)), $sampled(exp_ill_d1), $sampled(illegal));
            $display("Verification failed");
            $fatal(1, "illegal mismatch");
        end

    a_wb_valid: assert property (@(posedge clock) disable iff (rst)
        wb.valid == exp_wb_d2.valid)
        else begin
            $display("ERROR %s: wb.valid expected %0b actual %0b",
                     phase_name($sampled(ph_d2)), $sampled(exp_wb_d2.valid),
                     $sampled(wb.valid));
            $display("Verification failed");
            $fatal(1, "wb.valid mismatch");
        end

    a_wb_rd: assert property (@(posedge clock) disable iff (rst)
        wb.valid |-> wb.rd == exp_wb_d2.rd)
        else begin
            $display("ERROR %s: wb.rd expected %0d actual %0d",
                     phase_name($sampled(ph_d2)), $sampled(exp_wb_d2.rd), $sampled(wb.rd));
            $display("Verification failed");
            $fatal(1, "wb.rd mismatch");
        end

    a_wb_data: assert property (@(posedge clock) disable iff (rst)
        wb.valid |-> wb.data == exp_wb_d2.data)
        else begin
            $display("ERROR %s: wb.data expected %08h actual %08h",
                     phase_name($sampled(ph_d2)), $sampled(exp_wb_d2.data),
                     $sampled(wb.data));
            $display("Verification failed");
            $fatal(1, "wb.data mismatch");
        end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        int          n;
        logic [31:0] r;
        logic [31:0] w;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lcg_state   = 32'hda44_56b8;
        exp_wb_now  = '0;
        exp_ill_now = 1'b0;
        ph_now      = 0;
        for (n = 0; n < `EXEC_NREGS; n++)
            model_regs[n] = '0;
        for (n = 0; n < 16; n++)
            @(posedge clock);
        rst <= 1'b0;

        // Quiet after reset, then every register reads zero
        repeat (5) idle();
        for (n = 0; n < 32; n++)
            issue(r_word(isa_pkg::F7_BASE, 5'd0, n[4:0], isa_pkg::F3_ADD_SUB, 5'd0), 1);

        // Seed registers, half of them negative
        for (n = 1; n < 32; n++) begin
            r = rand32();
            issue(i_word(r[11:0], 5'd0, isa_pkg::F3_ADD_SUB, n[4:0]), 2);
        end
        for (n = 0; n < 300; n++) begin
            r  = rand32();
            f3 = r[2:0];
            f7 = (r[3] && (f3 == isa_pkg::F3_ADD_SUB || f3 == isa_pkg::F3_SR)) ?
                 isa_pkg::F7_ALT : isa_pkg::F7_BASE;
            issue(r_word(f7, r[8:4], r[13:9], f3, r[18:14]), 2);
            if (r[31:29] == 3'b000)
                idle();
        end

        // Immediate group, shifts keep a legal funct7
        for (n = 0; n < 300; n++) begin
            r  = rand32();
            f3 = r[2:0];
            if (f3 == isa_pkg::F3_SLL)
                f7 = isa_pkg::F7_BASE;
            else if (f3 == isa_pkg::F3_SR)
                f7 = r[19] ? isa_pkg::F7_ALT : isa_pkg::F7_BASE;
            else
                f7 = r[31:25];
            issue(i_word({f7, r[24:20]}, r[8:4], f3, r[13:9]), 3);
        end
        issue(i_word(12'h896, 5'd0, isa_pkg::F3_ADD_SUB, 5'd31), 3);   // Negative source
        for (n = 0; n < 32; n++) begin
            issue(i_word({isa_pkg::F7_ALT, n[4:0]}, 5'd31, isa_pkg::F3_SR, 5'd30), 3);
            issue(i_word({isa_pkg::F7_BASE, n[4:0]}, 5'd31, isa_pkg::F3_SR, 5'd29), 3);
            issue(i_word({isa_pkg::F7_BASE, n[4:0]}, 5'd31, isa_pkg::F3_SLL, 5'd28), 3);
        end

        // Each instruction reads the previous rd, no gaps
        prev_rd = 5'd1;
        for (n = 0; n < 100; n++) begin
            r   = rand32();
            f3  = r[14:12];
            rd  = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
            rs2 = r[6] ? prev_rd : r[11:7];
            if (f3 == isa_pkg::F3_ADD_SUB || f3 == isa_pkg::F3_SR)
                f7 = r[7] ? isa_pkg::F7_ALT : isa_pkg::F7_BASE;
            else
                f7 = isa_pkg::F7_BASE;
            if (r[5])
                issue(r_word(f7, rs2, prev_rd, f3, rd), 4);
            else if (f3 == isa_pkg::F3_SLL || f3 == isa_pkg::F3_SR)
                issue(i_word({f7, r[24:20]}, prev_rd, f3, rd), 4);
            else
                issue(i_word(r[31:20], prev_rd, f3, rd), 4);
            prev_rd = rd;
        end

        // x0 as destination, then as source
        for (n = 0; n < 8; n++) begin
            r = rand32();
            issue(i_word(r[31:20] | 12'h001, r[8:4], isa_pkg::F3_ADD_SUB, 5'd0), 5);
            issue(r_word(isa_pkg::F7_BASE, 5'd0, 5'd0, isa_pkg::F3_OR, r[13:9]), 5);
            issue(r_word(isa_pkg::F7_BASE, r[18:14], 5'd0, isa_pkg::F3_ADD_SUB, 5'd0), 5);
        end

        // Bad encodings, each followed by a read of its rd
        for (n = 0; n < 60; n++) begin
            r = rand32();
            case (n % 3)
                0: begin
                    w = rand32();
                    if (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011)
                        w[2] = ~w[2];               // Off OP and OP-IMM
                end
                1:       w = r_word(isa_pkg::F7_ALT, r[8:4], r[13:9], isa_pkg::F3_XOR, r[18:14]);
                default: w = i_word({r[31:26], 1'b1, r[24:20]}, r[8:4], isa_pkg::F3_SLL,
                                    r[13:9]);
            endcase
            issue(w, 6);
            issue(r_word(isa_pkg::F7_BASE, 5'd0, w[11:7], isa_pkg::F3_ADD_SUB, 5'd0), 6);
        end
        for (n = 1; n < 32; n++)
            issue(r_word(isa_pkg::F7_BASE, 5'd0, n[4:0], isa_pkg::F3_ADD_SUB, 5'd0), 6);

        idle();
        wait_drain(20);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+hw
hw/isa_pkg.sv
hw/exec_pkg.sv
hw/exec_decoder.sv
hw/exec_regfile.sv
hw/exec_alu.sv
hw/exec_core.sv
verif/exec_core_tb.sv

//--- Makefile
# Verilator build for the execute block testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= exec_core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
SIM       ?= $(BUILD_DIR)/V$(TOP)

SRCS := $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass/fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
